// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the transposition table testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir

verilator --binary --timing --assert -f vlog.f --top-module tb_vchess_trans \
   --Mdir "$BUILD_DIR" -o tb_vchess_trans
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

"./$BUILD_DIR/tb_vchess_trans" 2>&1 | tee "$LOG"
status=${PIPESTATUS[0]}
if [ "$status" -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q '\*\*\* TEST FAILED \*\*\*' "$LOG"; then
   echo "Failure reported in $LOG"
   exit 1
fi
exit 0

// ==== testbench/tb_vchess_trans.sv ====
`timescale 1ns/100ps

module tb_vchess_trans
   import vchess_pkg::*;
();

   localparam EVAL_WIDTH = 16;
   localparam MAX_POSITIONS_LOG2 = 6;
   localparam TABLE_ADDR_WIDTH = 8;
   localparam NUM_TESTS = 8;
   localparam NUM_POSITIONS = 20;
   localparam COLLIDE_POS = 19;             // Shares its table slot with position 0
   localparam SEED = 43265;

   typedef enum logic {OP_STORE, OP_LOOKUP} op_t;

   logic clk;
   logic reset;
   logic init;
   logic board_valid;
   logic [BOARD_WIDTH-1:0] board;
   logic white_to_move;
   logic [3:0] castle_mask;
   logic [3:0] en_passant_col;
   logic store;
   logic signed [EVAL_WIDTH-1:0] store_eval;
   logic [7:0] store_depth;
   flag_t store_flag;
   logic [TRANS_NODES_WIDTH-1:0] store_nodes;
   logic store_capture;
   logic [MAX_POSITIONS_LOG2-1:0] trans_table_index;
   logic busy;
   logic entry_valid;
   logic signed [EVAL_WIDTH-1:0] eval;
   logic [7:0] depth;
   flag_t flag;
   logic [TRANS_NODES_WIDTH-1:0] nodes;
   logic capture;
   logic collision;

   // Stimulus table, one row per test
   string row_name [NUM_TESTS];
   op_t row_op [NUM_TESTS];
   int row_first [NUM_TESTS];
   int row_count [NUM_TESTS];
   logic signed [EVAL_WIDTH-1:0] row_eval [NUM_TESTS];
   logic [7:0] row_depth [NUM_TESTS];
   flag_t row_flag [NUM_TESTS];
   logic [TRANS_NODES_WIDTH-1:0] row_nodes [NUM_TESTS];
   logic row_capture [NUM_TESTS];

   logic [BOARD_WIDTH-1:0] pos_board [NUM_POSITIONS];
   logic pos_wtm [NUM_POSITIONS];
   logic [3:0] pos_castle [NUM_POSITIONS];
   logic [3:0] pos_ep [NUM_POSITIONS];

   // Reference copy of the table memory
   logic model_valid [2**TABLE_ADDR_WIDTH];
   logic [HASH_WIDTH-1:0] model_tag [2**TABLE_ADDR_WIDTH];
   logic signed [EVAL_WIDTH-1:0] model_eval [2**TABLE_ADDR_WIDTH];
   logic [7:0] model_depth [2**TABLE_ADDR_WIDTH];
   logic [1:0] model_flag [2**TABLE_ADDR_WIDTH];
   logic [TRANS_NODES_WIDTH-1:0] model_nodes [2**TABLE_ADDR_WIDTH];
   logic model_capture [2**TABLE_ADDR_WIDTH];

   int checks;
   int mismatches;
   int failures;

   vchess_trans_top #(
      .EVAL_WIDTH         (EVAL_WIDTH),
      .MAX_POSITIONS_LOG2 (MAX_POSITIONS_LOG2),
      .TABLE_ADDR_WIDTH   (TABLE_ADDR_WIDTH)
   ) vchess_trans_top_i
   (
      .clk               (clk),
      .reset             (reset),
      .init              (init),
      .board_valid       (board_valid),
      .board             (board),
      .white_to_move     (white_to_move),
      .castle_mask       (castle_mask),
      .en_passant_col    (en_passant_col),
      .store             (store),
      .store_eval        (store_eval),
      .store_depth       (store_depth),
      .store_flag        (store_flag),
      .store_nodes       (store_nodes),
      .store_capture     (store_capture),
      .trans_table_index (trans_table_index),
      .busy              (busy),
      .entry_valid       (entry_valid),
      .eval              (eval),
      .depth             (depth),
      .flag              (flag),
      .nodes             (nodes),
      .capture           (capture),
      .collision         (collision)
   );

   always #2 clk = ~clk;                     // 4 ns period

   // Eight board slices folded together, state bits in the low 9 bits
   function automatic logic [HASH_WIDTH-1:0] hash_of(input int p);
      logic [HASH_WIDTH-1:0] h;
      h = {23'd0, pos_wtm[p], pos_castle[p], pos_ep[p]};
      for (int i = 0; i < BOARD_WIDTH / HASH_WIDTH; i++)
         h = h ^ pos_board[p][i * HASH_WIDTH +: HASH_WIDTH];
      return h;
   endfunction

   function automatic logic [TABLE_ADDR_WIDTH-1:0] addr_of(input int p);
      logic [HASH_WIDTH-1:0] h;
      h = hash_of(p);
      return h[TABLE_ADDR_WIDTH-1:0];
   endfunction

   task automatic add_row(input int r, input string name, input op_t op, input int first,
                          input int count, input int eval_v, input int depth_v,
                          input flag_t flag_v, input int nodes_v, input logic capture_v);
      row_name[r] = name;
      row_op[r] = op;
      row_first[r] = first;
      row_count[r] = count;
      row_eval[r] = EVAL_WIDTH'(eval_v);
      row_depth[r] = 8'(depth_v);
      row_flag[r] = flag_v;
      row_nodes[r] = TRANS_NODES_WIDTH'(nodes_v);
      row_capture[r] = capture_v;
   endtask

   task automatic build_table();
      add_row(0, "store_first", OP_STORE, 0, 4, 100, 5, FLAG_EXACT, 1000, 1'b1);
      add_row(1, "hit_first", OP_LOOKUP, 0, 4, 0, 0, FLAG_EXACT, 0, 1'b0);
      add_row(2, "miss_new", OP_LOOKUP, 4, 4, 0, 0, FLAG_EXACT, 0, 1'b0);
      add_row(3, "collision", OP_LOOKUP, COLLIDE_POS, 1, 0, 0, FLAG_EXACT, 0, 1'b0);
      add_row(4, "store_overwrite", OP_STORE, 0, 2, -250, 9, FLAG_LOWER, 50000, 1'b0);
      add_row(5, "hit_overwrite", OP_LOOKUP, 0, 2, 0, 0, FLAG_EXACT, 0, 1'b0);
      add_row(6, "queue_20", OP_LOOKUP, 0, 20, 0, 0, FLAG_EXACT, 0, 1'b0);
      add_row(7, "init_restart", OP_LOOKUP, 5, 1, 0, 0, FLAG_EXACT, 0, 1'b0);
   endtask

   // Random positions, each in a table slot of its own
   task automatic make_positions();
      logic unique_addr;
      for (int p = 0; p < NUM_POSITIONS; p++)
      begin
         unique_addr = 1'b0;
         while (!unique_addr)
         begin
            for (int w = 0; w < BOARD_WIDTH / 32; w++)
               pos_board[p][w * 32 +: 32] = $urandom();
            pos_wtm[p] = 1'($urandom());
            pos_castle[p] = 4'($urandom());
            pos_ep[p] = 4'($urandom());
            unique_addr = 1'b1;
            for (int q = 0; q < p; q++)
               if (addr_of(q) == addr_of(p))
                  unique_addr = 1'b0;
         end
      end
      // Board bit 12 moves hash bit 12 only, the address bits stay
      pos_board[COLLIDE_POS] = pos_board[0];
      pos_board[COLLIDE_POS][12] = ~pos_board[0][12];
      pos_wtm[COLLIDE_POS] = pos_wtm[0];
      pos_castle[COLLIDE_POS] = pos_castle[0];
      pos_ep[COLLIDE_POS] = pos_ep[0];
   endtask

   task automatic drive_position(input int p);
      board = pos_board[p];
      white_to_move = pos_wtm[p];
      castle_mask = pos_castle[p];
      en_passant_col = pos_ep[p];
   endtask

   task automatic wait_idle(input string name);
      int cycles;
      cycles = 0;
      while (busy && cycles < 400)
      begin
         @(posedge clk);
         #1;
         cycles++;
      end
      if (busy)
      begin
         $display("Error in %s: busy stayed high for %0d cycles", name, cycles);
         failures++;
      end
   endtask

   task automatic check_value(input string name, input int k, input string field,
                              input logic [31:0] expected, input logic [31:0] actual);
      checks++;
      if (expected !== actual)
      begin
         $display("Mismatch %s index %0d %s: expected 0x%0h, actual 0x%0h",
                  name, k, field, expected, actual);
         mismatches++;
      end
   endtask

   task automatic run_store(input int r);
      int p;
      logic [TABLE_ADDR_WIDTH-1:0] a;
      for (int k = 0; k < row_count[r]; k++)
      begin
         p = row_first[r] + k;
         wait_idle(row_name[r]);
         drive_position(p);
         store_eval = row_eval[r] + EVAL_WIDTH'(k);
         store_depth = row_depth[r];
         store_flag = row_flag[r];
         store_nodes = row_nodes[r] + TRANS_NODES_WIDTH'(k);
         store_capture = row_capture[r];
         store = 1'b1;
         @(posedge clk);
         #1;
         store = 1'b0;
         a = addr_of(p);                     // Store overwrites the whole slot
         model_valid[a] = 1'b1;
         model_tag[a] = hash_of(p);
         model_eval[a] = store_eval;
         model_depth[a] = store_depth;
         model_flag[a] = store_flag;
         model_nodes[a] = store_nodes;
         model_capture[a] = store_capture;
      end
      wait_idle(row_name[r]);
   endtask

   task automatic check_result(input int r, input int k, input int p);
      logic [HASH_WIDTH-1:0] h;
      logic [TABLE_ADDR_WIDTH-1:0] a;
      logic hit;
      logic coll;
      h = hash_of(p);
      a = h[TABLE_ADDR_WIDTH-1:0];
      hit = model_valid[a] && (model_tag[a] == h);
      coll = model_valid[a] && !hit;
      check_value(row_name[r], k, "entry_valid", 32'(hit), 32'(entry_valid));
      check_value(row_name[r], k, "collision", 32'(coll), 32'(collision));
      check_value(row_name[r], k, "eval", hit ? 32'(model_eval[a]) : 32'd0, 32'(eval));
      check_value(row_name[r], k, "depth", hit ? 32'(model_depth[a]) : 32'd0, 32'(depth));
      check_value(row_name[r], k, "flag", hit ? 32'(model_flag[a]) : 32'd0, 32'(flag));
      check_value(row_name[r], k, "nodes", hit ? 32'(model_nodes[a]) : 32'd0, 32'(nodes));
      check_value(row_name[r], k, "capture", 32'(hit && model_capture[a]), 32'(capture));
   endtask

   task automatic run_lookup(input int r);
      wait_idle(row_name[r]);
      init = 1'b1;                           // Results restart at index 0
      @(posedge clk);
      #1;
      init = 1'b0;
      for (int k = 0; k < row_count[r]; k++)
      begin
         drive_position(row_first[r] + k);
         board_valid = 1'b1;
         @(posedge clk);
         #1;
         board_valid = 1'b0;
         checks++;
         if (!busy)
         begin
            $display("Error in %s: busy low after position %0d was queued", row_name[r], k);
            failures++;
         end
         @(posedge clk);
         #1;
      end
      wait_idle(row_name[r]);
      // Last result read first, it must be in the table once busy is low
      for (int k = row_count[r] - 1; k >= 0; k--)
      begin
         trans_table_index = MAX_POSITIONS_LOG2'(k);
         @(posedge clk);
         #1;                                 // Registered read, one cycle late
         check_result(r, k, row_first[r] + k);
      end
   endtask

   initial
   begin
      int seed_result;
      seed_result = $urandom(SEED);
      clk = 1'b0;
      reset = 1'b1;
      init = 1'b0;
      board_valid = 1'b0;
      board = '0;
      white_to_move = 1'b0;
      castle_mask = '0;
      en_passant_col = '0;
      store = 1'b0;
      store_eval = '0;
      store_depth = '0;
      store_flag = FLAG_EXACT;
      store_nodes = '0;
      store_capture = 1'b0;
      trans_table_index = '0;
      checks = 0;
      mismatches = 0;
      failures = 0;
      for (int a = 0; a < 2**TABLE_ADDR_WIDTH; a++)
         model_valid[a] = 1'b0;
      build_table();
      make_positions();
      repeat (10) @(posedge clk);
      #1;
      reset = 1'b0;
      for (int r = 0; r < NUM_TESTS; r++)
      begin
         if (row_op[r] == OP_STORE)
            run_store(r);
         else
            run_lookup(r);
      end
      $display("Checks: %0d, mismatches: %0d, other errors: %0d", checks, mismatches, failures);
      if (mismatches == 0 && failures == 0)
         $display("*** TEST PASSED ***");
      else
         $display("*** TEST FAILED ***");
      $finish;
   end

   // Watchdog
   initial
   begin
      repeat (NUM_TESTS * 200) @(posedge clk);
      $display("Timeout: run did not finish within %0d cycles", NUM_TESTS * 200);
      $display("Checks: %0d, mismatches: %0d, other errors: %0d", checks, mismatches, failures);
      $display("*** TEST FAILED ***");
      $finish;
   end

endmodule

// ==== testbench/tb_vchess_trans_assert.sv ====
`timescale 1ns/100ps

module tb_vchess_trans_assert
#(
   parameter FIFO_DEPTH = 128,
   parameter COUNT_WIDTH = 8
)
(
   input logic                   clk,
   input logic                   reset,
   input logic                   busy,
   input logic                   store,
   input logic [COUNT_WIDTH-1:0] fifo_count
);

   // Controller, FIFO and trans all come out of reset idle
   busy_after_reset: assert property (@(posedge clk) reset |=> !busy)
      else $error("busy high in the cycle after reset");

   store_while_busy: assert property (@(posedge clk) disable iff (reset) !(store && busy))
      else $error("store strobe given while busy");

   fifo_overflow: assert property (@(posedge clk) disable iff (reset) fifo_count <= FIFO_DEPTH)
      else $error("position FIFO count above its depth");   // No back-pressure on board_valid

endmodule

bind vchess_trans_top tb_vchess_trans_assert #(
   .FIFO_DEPTH  (2 ** (MAX_POSITIONS_LOG2 + 1)),
   .COUNT_WIDTH (MAX_POSITIONS_LOG2 + 2)
) tb_vchess_trans_assert_i
(
   .clk        (clk),
   .reset      (reset),
   .busy       (busy),
   .store      (store),
   .fifo_count (am_trans_i.fifo_count)
);

// ==== verilog/am_trans.sv ====
`timescale 1ns/100ps

module am_trans
   import vchess_pkg::*;
#(
   parameter EVAL_WIDTH = 16,
   parameter MAX_POSITIONS_LOG2 = 6,
   parameter TABLE_ADDR_WIDTH = 8,
   localparam ENTRY_WIDTH = 1 + HASH_WIDTH + EVAL_WIDTH + 8 + 2 + TRANS_NODES_WIDTH + 1
)
(
   input  logic                          clk,
   input  logic                          reset,
   input  logic                          init,
   input  logic                          board_valid,
   input  logic [BOARD_WIDTH-1:0]        board,
   input  logic                          white_to_move,
   input  logic [3:0]                    castle_mask,
   input  logic [3:0]                    en_passant_col,
   input  logic                          store,
   input  logic signed [EVAL_WIDTH-1:0]  store_eval,
   input  logic [7:0]                    store_depth,
   input  flag_t                         store_flag,
   input  logic [TRANS_NODES_WIDTH-1:0]  store_nodes,
   input  logic                          store_capture,
   input  logic [MAX_POSITIONS_LOG2-1:0] trans_table_index,
   output logic                          busy,
   output logic                          entry_valid,
   output logic signed [EVAL_WIDTH-1:0]  eval,
   output logic [7:0]                    depth,
   output flag_t                         flag,
   output logic [TRANS_NODES_WIDTH-1:0]  nodes,
   output logic                          capture,
   output logic                          collision,
   output logic                          mem_rd_en,
   output logic [TABLE_ADDR_WIDTH-1:0]   mem_rd_addr,
   input  logic [ENTRY_WIDTH-1:0]        mem_rd_data,
   output logic                          mem_wr_en,
   output logic [TABLE_ADDR_WIDTH-1:0]   mem_wr_addr,
   output logic [ENTRY_WIDTH-1:0]        mem_wr_data
);

   localparam FIFO_DEPTH_LOG2 = MAX_POSITIONS_LOG2 + 1;  // Twice the result table
   localparam FIFO_WIDTH = BOARD_WIDTH + 9;
   localparam RESULT_WIDTH = 1 + EVAL_WIDTH + 8 + 2 + TRANS_NODES_WIDTH + 1 + 1;

   logic [FIFO_WIDTH-1:0] fifo [2**FIFO_DEPTH_LOG2];
   logic [FIFO_DEPTH_LOG2-1:0] fifo_wr_addr;
   logic [FIFO_DEPTH_LOG2-1:0] fifo_rd_addr;
   logic [FIFO_DEPTH_LOG2:0] fifo_count;
   logic fifo_wr_en;
   logic fifo_rd_en;
   logic board_valid_r;

   logic [RESULT_WIDTH-1:0] result_table [2**MAX_POSITIONS_LOG2];
   logic [RESULT_WIDTH-1:0] result_q;
   logic [MAX_POSITIONS_LOG2-1:0] table_wr_addr;
   logic table_wr_en;
   logic [1:0] result_flag;

   logic [BOARD_WIDTH-1:0] local_board;
   logic local_white_to_move;
   logic [3:0] local_castle_mask;
   logic [3:0] local_en_passant_col;
   logic signed [EVAL_WIDTH-1:0] local_eval;
   logic [7:0] local_depth;
   flag_t local_flag;
   logic [TRANS_NODES_WIDTH-1:0] local_nodes;
   logic local_capture;
   logic store_pending;
   logic store_accept;

   logic entry_lookup;
   logic entry_store;
   logic trans_idle;
   logic table_entry_valid;
   logic signed [EVAL_WIDTH-1:0] table_eval;
   logic [7:0] table_depth;
   flag_t table_flag;
   logic [TRANS_NODES_WIDTH-1:0] table_nodes;
   logic table_capture;
   logic table_collision;

   am_state_t state;

   assign fifo_wr_en = board_valid && !board_valid_r;     // Rising edge queues one position
   assign fifo_rd_en = (state == AM_FIFO_POP);
   assign store_accept = store && !busy;
   assign entry_lookup = (state == AM_LOOKUP);
   assign entry_store = (state == AM_STORE);
   assign table_wr_en = (state == AM_WRITE_TABLE);
   // A store still being written by trans also counts
   assign busy = (fifo_count != 0) || store_pending || (state != AM_IDLE) || !trans_idle;

   always_ff @(posedge clk)
   begin
      if (reset)
         board_valid_r <= 1'b0;
      else
         board_valid_r <= board_valid;
   end

   always_ff @(posedge clk)
   begin
      if (fifo_wr_en)
         fifo[fifo_wr_addr] <= {white_to_move, castle_mask, en_passant_col, board};
   end

   always_ff @(posedge clk)
   begin
      if (reset || init)
      begin
         fifo_wr_addr <= '0;
         fifo_rd_addr <= '0;
         fifo_count <= '0;
      end
      else
      begin
         if (fifo_wr_en)
            fifo_wr_addr <= fifo_wr_addr + 1'b1;
         if (fifo_rd_en)
            fifo_rd_addr <= fifo_rd_addr + 1'b1;
         if (fifo_wr_en && !fifo_rd_en)
            fifo_count <= fifo_count + 1'b1;
         else if (!fifo_wr_en && fifo_rd_en)
            fifo_count <= fifo_count - 1'b1;
      end
   end

   // Position and fields presented to trans, from the FIFO or a store
   always_ff @(posedge clk)
   begin
      if (fifo_rd_en)
         {local_white_to_move, local_castle_mask, local_en_passant_col, local_board} <=
            fifo[fifo_rd_addr];
      else if (store_accept)
      begin
         local_board <= board;
         local_white_to_move <= white_to_move;
         local_castle_mask <= castle_mask;
         local_en_passant_col <= en_passant_col;
         local_eval <= store_eval;
         local_depth <= store_depth;
         local_flag <= store_flag;
         local_nodes <= store_nodes;
         local_capture <= store_capture;
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state <= AM_IDLE;
         store_pending <= 1'b0;
      end
      else
      begin
         if (store_accept)
            store_pending <= 1'b1;
         else if (state == AM_STORE)
            store_pending <= 1'b0;
         case (state)
            AM_IDLE:
               if (trans_idle && store_pending)        // Store goes ahead of the FIFO
                  state <= AM_STORE;
               else if (trans_idle && fifo_count != 0)
                  state <= AM_FIFO_POP;
            AM_FIFO_POP:
               state <= AM_LOOKUP;
            AM_LOOKUP:
               state <= AM_WAIT_LOOKUP;
            AM_WAIT_LOOKUP:
               if (trans_idle)
                  state <= AM_WRITE_TABLE;
            AM_WRITE_TABLE, AM_STORE:
               state <= AM_IDLE;
            default:
               state <= AM_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset || init)
         table_wr_addr <= '0;
      else if (table_wr_en)
         table_wr_addr <= table_wr_addr + 1'b1;    // Results in arrival order
   end

   always_ff @(posedge clk)
   begin
      if (table_wr_en)
         result_table[table_wr_addr] <= {table_entry_valid, table_eval, table_depth,
                                         table_flag, table_nodes, table_capture,
                                         table_collision};
      result_q <= result_table[trans_table_index];
   end

   assign {entry_valid, eval, depth, result_flag, nodes, capture, collision} = result_q;
   assign flag = flag_t'(result_flag);

   trans #(
      .EVAL_WIDTH       (EVAL_WIDTH),
      .TABLE_ADDR_WIDTH (TABLE_ADDR_WIDTH)
   ) trans_i
   (
      .clk            (clk),
      .reset          (reset),
      .entry_lookup   (entry_lookup),
      .entry_store    (entry_store),
      .board          (local_board),
      .white_to_move  (local_white_to_move),
      .castle_mask    (local_castle_mask),
      .en_passant_col (local_en_passant_col),
      .eval_in        (local_eval),
      .depth_in       (local_depth),
      .flag_in        (local_flag),
      .nodes_in       (local_nodes),
      .capture_in     (local_capture),
      .trans_idle     (trans_idle),
      .entry_valid    (table_entry_valid),
      .eval           (table_eval),
      .depth          (table_depth),
      .flag           (table_flag),
      .nodes          (table_nodes),
      .capture        (table_capture),
      .collision      (table_collision),
      .mem_rd_en      (mem_rd_en),
      .mem_rd_addr    (mem_rd_addr),
      .mem_rd_data    (mem_rd_data),
      .mem_wr_en      (mem_wr_en),
      .mem_wr_addr    (mem_wr_addr),
      .mem_wr_data    (mem_wr_data)
   );

endmodule

// ==== verilog/board_hash.sv ====
`timescale 1ns/100ps

module board_hash
   import vchess_pkg::*;
(
   input  logic                   clk,
   input  logic [BOARD_WIDTH-1:0] board,
   input  logic                   white_to_move,
   input  logic [3:0]             castle_mask,
   input  logic [3:0]             en_passant_col,
   output logic [HASH_WIDTH-1:0]  hash
);

   localparam SLICES = BOARD_WIDTH / HASH_WIDTH;

   logic [HASH_WIDTH-1:0] fold;

   // Side to move, castling and en passant sit in the low 9 bits
   always_comb
   begin
      fold = {{(HASH_WIDTH - 9){1'b0}}, white_to_move, castle_mask, en_passant_col};
      for (int i = 0; i < SLICES; i++)
         fold = fold ^ board[i * HASH_WIDTH +: HASH_WIDTH];
   end

   always_ff @(posedge clk)
   begin
      hash <= fold;                       // One pipeline stage
   end

endmodule

// ==== verilog/trans.sv ====
`timescale 1ns/100ps

module trans
   import vchess_pkg::*;
#(
   parameter EVAL_WIDTH = 16,
   parameter TABLE_ADDR_WIDTH = 8,
   localparam ENTRY_WIDTH = 1 + HASH_WIDTH + EVAL_WIDTH + 8 + 2 + TRANS_NODES_WIDTH + 1
)
(
   input  logic                          clk,
   input  logic                          reset,
   input  logic                          entry_lookup,
   input  logic                          entry_store,
   input  logic [BOARD_WIDTH-1:0]        board,
   input  logic                          white_to_move,
   input  logic [3:0]                    castle_mask,
   input  logic [3:0]                    en_passant_col,
   input  logic signed [EVAL_WIDTH-1:0]  eval_in,
   input  logic [7:0]                    depth_in,
   input  flag_t                         flag_in,
   input  logic [TRANS_NODES_WIDTH-1:0]  nodes_in,
   input  logic                          capture_in,
   output logic                          trans_idle,
   output logic                          entry_valid,
   output logic signed [EVAL_WIDTH-1:0]  eval,
   output logic [7:0]                    depth,
   output flag_t                         flag,
   output logic [TRANS_NODES_WIDTH-1:0]  nodes,
   output logic                          capture,
   output logic                          collision,
   output logic                          mem_rd_en,
   output logic [TABLE_ADDR_WIDTH-1:0]   mem_rd_addr,
   input  logic [ENTRY_WIDTH-1:0]        mem_rd_data,
   output logic                          mem_wr_en,
   output logic [TABLE_ADDR_WIDTH-1:0]   mem_wr_addr,
   output logic [ENTRY_WIDTH-1:0]        mem_wr_data
);

   trans_state_t state;
   logic is_store;
   logic [HASH_WIDTH-1:0] hash;
   logic [HASH_WIDTH-1:0] hash_r;
   logic signed [EVAL_WIDTH-1:0] eval_r;
   logic [7:0] depth_r;
   flag_t flag_r;
   logic [TRANS_NODES_WIDTH-1:0] nodes_r;
   logic capture_r;

   logic rd_valid;
   logic [HASH_WIDTH-1:0] rd_tag;
   logic signed [EVAL_WIDTH-1:0] rd_eval;
   logic [7:0] rd_depth;
   logic [1:0] rd_flag;
   logic [TRANS_NODES_WIDTH-1:0] rd_nodes;
   logic rd_capture;
   logic hit;

   board_hash board_hash_i
   (
      .clk            (clk),
      .board          (board),
      .white_to_move  (white_to_move),
      .castle_mask    (castle_mask),
      .en_passant_col (en_passant_col),
      .hash           (hash)
   );

   assign {rd_valid, rd_tag, rd_eval, rd_depth, rd_flag, rd_nodes, rd_capture} = mem_rd_data;
   assign hit = rd_valid && (rd_tag == hash_r);

   assign trans_idle = (state == TS_IDLE);
   assign mem_rd_en = (state == TS_READ);
   assign mem_rd_addr = hash_r[TABLE_ADDR_WIDTH-1:0];  // Low hash bits index the table
   assign mem_wr_en = (state == TS_WRITE);
   assign mem_wr_addr = hash_r[TABLE_ADDR_WIDTH-1:0];
   assign mem_wr_data = {1'b1, hash_r, eval_r, depth_r, flag_r, nodes_r, capture_r};

   always_ff @(posedge clk)
   begin
      if (reset)
         state <= TS_IDLE;
      else
         case (state)
            TS_IDLE:
               if (entry_store || entry_lookup)
                  state <= TS_HASH;
            TS_HASH:
               state <= is_store ? TS_WRITE : TS_READ;
            TS_READ:
               state <= TS_COMPARE;
            TS_COMPARE, TS_WRITE:
               state <= TS_IDLE;
            default:
               state <= TS_IDLE;
         endcase
   end

   always_ff @(posedge clk)
   begin
      if (trans_idle && (entry_store || entry_lookup))
      begin
         is_store <= entry_store;           // Store wins if both strobes come
         eval_r <= eval_in;
         depth_r <= depth_in;
         flag_r <= flag_in;
         nodes_r <= nodes_in;
         capture_r <= capture_in;
      end
      if (state == TS_HASH)
         hash_r <= hash;                     // Board input may move on after this
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         entry_valid <= 1'b0;
         collision <= 1'b0;
      end
      else if (state == TS_COMPARE)
      begin
         entry_valid <= hit;
         collision <= rd_valid && !hit;      // Slot taken by another position
      end
   end

   // Data fields are zero unless the tag matched
   always_ff @(posedge clk)
   begin
      if (state == TS_COMPARE)
      begin
         eval <= hit ? rd_eval : '0;
         depth <= hit ? rd_depth : '0;
         flag <= flag_t'(hit ? rd_flag : 2'b00);
         nodes <= hit ? rd_nodes : '0;
         capture <= hit && rd_capture;
      end
   end

endmodule

// ==== verilog/trans_mem.sv ====
`timescale 1ns/100ps

module trans_mem
   import vchess_pkg::*;
#(
   parameter EVAL_WIDTH = 16,
   parameter TABLE_ADDR_WIDTH = 8,
   localparam ENTRY_WIDTH = 1 + HASH_WIDTH + EVAL_WIDTH + 8 + 2 + TRANS_NODES_WIDTH + 1
)
(
   input  logic                        clk,
   input  logic                        reset,
   input  logic                        wr_en,
   input  logic [TABLE_ADDR_WIDTH-1:0] wr_addr,
   input  logic [ENTRY_WIDTH-1:0]      wr_data,
   input  logic                        rd_en,
   input  logic [TABLE_ADDR_WIDTH-1:0] rd_addr,
   output logic [ENTRY_WIDTH-1:0]      rd_data
);

   logic [ENTRY_WIDTH-2:0] mem [2**TABLE_ADDR_WIDTH];  // Entry word without its valid bit
   logic [2**TABLE_ADDR_WIDTH-1:0] valid_bits;

   always_ff @(posedge clk)
   begin
      if (wr_en)
         mem[wr_addr] <= wr_data[ENTRY_WIDTH-2:0];
      if (rd_en)
         rd_data <= {valid_bits[rd_addr], mem[rd_addr]};
   end

   // Unwritten slots read back as invalid
   always_ff @(posedge clk)
   begin
      if (reset)
         valid_bits <= '0;
      else if (wr_en)
         valid_bits[wr_addr] <= wr_data[ENTRY_WIDTH-1];
   end

endmodule

// ==== verilog/vchess_pkg.sv ====
package vchess_pkg;

   localparam int BOARD_WIDTH = 256;       // 64 squares, 4 bits each
   localparam int TRANS_NODES_WIDTH = 24;
   localparam int HASH_WIDTH = 32;         // Full hash is kept as the tag

   // Bound kind of a stored evaluation
   typedef enum logic [1:0]
   {
      FLAG_EXACT,
      FLAG_LOWER,
      FLAG_UPPER
   } flag_t;

   // Transposition unit FSM
   typedef enum logic [2:0]
   {
      TS_IDLE,
      TS_HASH,                              // Wait for the registered hash
      TS_READ,                              // Read strobe to table memory
      TS_COMPARE,                           // Tag compare on read data
      TS_WRITE                              // Store of an entry word
   } trans_state_t;

   // Batch controller FSM
   typedef enum logic [2:0]
   {
      AM_IDLE,
      AM_FIFO_POP,
      AM_LOOKUP,
      AM_WAIT_LOOKUP,
      AM_WRITE_TABLE,
      AM_STORE
   } am_state_t;

endpackage

// ==== verilog/vchess_trans_top.sv ====
`timescale 1ns/100ps

module vchess_trans_top
   import vchess_pkg::*;
#(
   parameter EVAL_WIDTH = 16,
   parameter MAX_POSITIONS_LOG2 = 6,
   parameter TABLE_ADDR_WIDTH = 8
)
(
   input  logic                          clk,
   input  logic                          reset,
   input  logic                          init,
   input  logic                          board_valid,
   input  logic [BOARD_WIDTH-1:0]        board,
   input  logic                          white_to_move,
   input  logic [3:0]                    castle_mask,
   input  logic [3:0]                    en_passant_col,
   input  logic                          store,
   input  logic signed [EVAL_WIDTH-1:0]  store_eval,
   input  logic [7:0]                    store_depth,
   input  flag_t                         store_flag,
   input  logic [TRANS_NODES_WIDTH-1:0]  store_nodes,
   input  logic                          store_capture,
   input  logic [MAX_POSITIONS_LOG2-1:0] trans_table_index,
   output logic                          busy,
   output logic                          entry_valid,
   output logic signed [EVAL_WIDTH-1:0]  eval,
   output logic [7:0]                    depth,
   output flag_t                         flag,
   output logic [TRANS_NODES_WIDTH-1:0]  nodes,
   output logic                          capture,
   output logic                          collision
);

   localparam ENTRY_WIDTH = 1 + HASH_WIDTH + EVAL_WIDTH + 8 + 2 + TRANS_NODES_WIDTH + 1;

   logic mem_rd_en;
   logic [TABLE_ADDR_WIDTH-1:0] mem_rd_addr;
   logic [ENTRY_WIDTH-1:0] mem_rd_data;
   logic mem_wr_en;
   logic [TABLE_ADDR_WIDTH-1:0] mem_wr_addr;
   logic [ENTRY_WIDTH-1:0] mem_wr_data;

   am_trans #(
      .EVAL_WIDTH         (EVAL_WIDTH),
      .MAX_POSITIONS_LOG2 (MAX_POSITIONS_LOG2),
      .TABLE_ADDR_WIDTH   (TABLE_ADDR_WIDTH)
   ) am_trans_i
   (
      .clk               (clk),
      .reset             (reset),
      .init              (init),
      .board_valid       (board_valid),
      .board             (board),
      .white_to_move     (white_to_move),
      .castle_mask       (castle_mask),
      .en_passant_col    (en_passant_col),
      .store             (store),
      .store_eval        (store_eval),
      .store_depth       (store_depth),
      .store_flag        (store_flag),
      .store_nodes       (store_nodes),
      .store_capture     (store_capture),
      .trans_table_index (trans_table_index),
      .busy              (busy),
      .entry_valid       (entry_valid),
      .eval              (eval),
      .depth             (depth),
      .flag              (flag),
      .nodes             (nodes),
      .capture           (capture),
      .collision         (collision),
      .mem_rd_en         (mem_rd_en),
      .mem_rd_addr       (mem_rd_addr),
      .mem_rd_data       (mem_rd_data),
      .mem_wr_en         (mem_wr_en),
      .mem_wr_addr       (mem_wr_addr),
      .mem_wr_data       (mem_wr_data)
   );

   // On-chip stand-in for the external table memory
   trans_mem #(
      .EVAL_WIDTH       (EVAL_WIDTH),
      .TABLE_ADDR_WIDTH (TABLE_ADDR_WIDTH)
   ) trans_mem_i
   (
      .clk     (clk),
      .reset   (reset),
      .wr_en   (mem_wr_en),
      .wr_addr (mem_wr_addr),
      .wr_data (mem_wr_data),
      .rd_en   (mem_rd_en),
      .rd_addr (mem_rd_addr),
      .rd_data (mem_rd_data)
   );

endmodule

// ==== vlog.f ====
verilog/vchess_pkg.sv
verilog/board_hash.sv
verilog/trans.sv
verilog/am_trans.sv
verilog/trans_mem.sv
verilog/vchess_trans_top.sv
testbench/tb_vchess_trans_assert.sv
testbench/tb_vchess_trans.sv
